// ==== Makefile ====
TOP = frontend_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== frontend_chk.sv ====
module frontend_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 flush,
    input logic                 dec_allowin,
    input logic                 q_valid,
    input pipe_pkg::fetch_pkt_t q_pkt,
    input logic                 q_ready,
    input logic                 id_valid,
    input pipe_pkg::fetch_pkt_t id_pkt
);

    // register is empty right after reset or flush
    a_clear: assert property (@(posedge clk) (reset || flush) |=> !id_valid)
        else $error("id_valid high after reset or flush");

    // a stalled valid pair must not change
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (id_valid && !dec_allowin && !flush) |=> $stable(id_pkt))
        else $error("id_pkt changed while decode was stalled");

    // handshake with the queue takes the head packet
    a_load: assert property (@(posedge clk) disable iff (reset)
        (q_valid && q_ready && !flush) |=> (id_valid && id_pkt == $past(q_pkt)))
        else $error("head packet not loaded on queue handshake");

endmodule

bind queue_id_reg frontend_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .dec_allowin (dec_allowin),
    .q_valid     (q_valid),
    .q_pkt       (q_pkt),
    .q_ready     (q_ready),
    .id_valid    (id_valid),
    .id_pkt      (id_pkt)
);

// ==== frontend_tb.sv ====
module frontend_tb;

    logic                 clk;
    logic                 reset;
    logic                 flush;
    logic                 fetch_valid;
    pipe_pkg::fetch_pkt_t fetch_pkt;
    logic                 fetch_ready;
    logic                 dec_allowin;
    pipe_pkg::dec_pair_t  dec_out;

    logic [31:0] lfsr_state = 32'h1346f09a;

    // model state, updated on every rising edge
    pipe_pkg::fetch_pkt_t mq [$];
    logic                 m_valid;
    pipe_pkg::fetch_pkt_t m_pkt;
    logic                 model_started = 1'b0;

    frontend_top UUT (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt),
        .fetch_ready (fetch_ready),
        .dec_allowin (dec_allowin),
        .dec_out     (dec_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          b;
        v = '0;
        for (b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};  // one step per bit
        end
        return v;
    endfunction

    // half the words carry a legal opcode, the rest a random one
    function automatic logic [31:0] make_inst();
        logic [31:0] r;
        logic [5:0]  op;
        r = rand_bits(3);
        case (r[2:0])
            3'd0:    op = isa_pkg::op_alu_reg;
            3'd1:    op = isa_pkg::op_alu_imm;
            3'd2:    op = isa_pkg::op_branch;
            3'd3:    op = isa_pkg::op_nop;
            default: begin
                r  = rand_bits(6);
                op = r[5:0];
            end
        endcase
        r = rand_bits(26);
        return {op, r[25:0]};
    endfunction

    function automatic pipe_pkg::fetch_pkt_t make_pkt();
        pipe_pkg::fetch_pkt_t p;
        logic [31:0]          r;
        r             = rand_bits(30);
        p.pc          = {r[29:0], 2'b00};
        p.inst0       = make_inst();
        p.inst1       = make_inst();
        r             = rand_bits(2);
        p.pred_taken  = r[1:0];
        p.pred_target = rand_bits(32);
        r             = rand_bits(7);
        p.excp_code   = r[6:0];
        r             = rand_bits(1);
        p.excp_valid  = r[0];
        return p;
    endfunction

    function automatic pipe_pkg::fetch_pkt_t nop_packet();
        pipe_pkg::fetch_pkt_t p;
        p             = '0;
        p.pc          = pipe_pkg::pc_reset;
        p.inst0       = isa_pkg::inst_nop;
        p.inst1       = isa_pkg::inst_nop;
        p.pred_target = pipe_pkg::pc_reset + 32'd8;
        return p;
    endfunction

    // field positions taken straight from the encoding
    function automatic isa_pkg::dec_op_t model_decode(input logic [31:0] inst,
                                                      input logic [31:0] spc);
        isa_pkg::dec_op_t e;
        logic [31:0]      sx;
        e  = '0;
        sx = {{16{inst[15]}}, inst[15:0]};
        case (inst[31:26])
            isa_pkg::op_alu_reg: begin
                e.cls    = isa_pkg::cls_alu;
                e.alu_fn = inst[1:0];
                e.rd     = inst[25:21];
                e.rj     = inst[20:16];
                e.rk     = inst[15:11];
            end
            isa_pkg::op_alu_imm: begin
                e.cls     = isa_pkg::cls_alu;
                e.use_imm = 1'b1;
                e.rd      = inst[25:21];
                e.rj      = inst[20:16];
                e.imm     = sx;
            end
            isa_pkg::op_branch: begin
                e.cls    = isa_pkg::cls_branch;
                e.rd     = inst[25:21];
                e.rj     = inst[20:16];
                e.imm    = sx;
                e.target = spc + (sx << 2);
            end
            isa_pkg::op_nop: e.cls = isa_pkg::cls_nop;
            default:         e.cls = isa_pkg::cls_illegal;
        endcase
        return e;
    endfunction

    function automatic pipe_pkg::dec_pair_t model_pair(input logic v,
                                                       input pipe_pkg::fetch_pkt_t p);
        pipe_pkg::dec_pair_t d;
        d             = '0;
        d.valid       = v;
        d.pc          = p.pc;
        d.slot0       = model_decode(p.inst0, p.pc);
        d.slot1       = model_decode(p.inst1, p.pc + 32'd4);  // second word
        d.pred_taken  = p.pred_taken;
        d.pred_target = p.pred_target;
        d.excp_code   = p.excp_code;
        d.excp_valid  = p.excp_valid;
        return d;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_op(input isa_pkg::dec_op_t got, input isa_pkg::dec_op_t exp,
                              input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch at time %0t: %s got %h expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic compare_pair(input pipe_pkg::dec_pair_t got,
                                input pipe_pkg::dec_pair_t exp);
        compare_op(got.slot0, exp.slot0, "slot0");
        compare_op(got.slot1, exp.slot1, "slot1");
        if ({got.valid, got.pc, got.pred_taken, got.pred_target, got.excp_code,
             got.excp_valid} !== {exp.valid, exp.pc, exp.pred_taken, exp.pred_target,
                                  exp.excp_code, exp.excp_valid}) begin
            stop_with_failure($sformatf("mismatch at time %0t: pair got %h expected %h",
                                        $time, got, exp));
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch at time %0t: %s got %b expected %b",
                                        $time, what, got, exp));
        end
    endtask

    // reference model, sees the inputs as they were before this edge
    always @(posedge clk) begin : model_update
        logic push;
        model_started = 1'b1;
        if (reset || flush) begin
            mq.delete();
            m_valid = 1'b0;
            m_pkt   = nop_packet();
        end else begin
            push = fetch_valid && (mq.size() < pipe_pkg::queue_depth);  // count before pop
            if (dec_allowin) begin
                if (mq.size() == 0) begin
                    m_valid = 1'b0;
                    m_pkt   = nop_packet();
                end else begin
                    m_valid = 1'b1;
                    m_pkt   = mq.pop_front();
                end
            end
            if (push) begin
                mq.push_back(fetch_pkt);
            end
        end
    end

    always @(negedge clk) begin
        if (model_started) begin
            compare_bit(fetch_ready, mq.size() < pipe_pkg::queue_depth, "fetch_ready");
            compare_pair(dec_out, model_pair(m_valid, m_pkt));
        end
    end

    initial begin
        int          i;
        int          k;
        logic [31:0] r;
        reset       = 1'b1;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        dec_allowin = 1'b0;
        fetch_pkt   = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_pair(dec_out, model_pair(1'b0, nop_packet()));

        // random traffic with rare flushes
        for (i = 0; i < 600; i++) begin
            @(posedge clk);
            r = rand_bits(2);
            fetch_valid <= (r[1:0] != 2'b00);
            r = rand_bits(1);
            dec_allowin <= r[0];
            r = rand_bits(5);
            flush     <= (r[4:0] == 5'd0);
            fetch_pkt <= make_pkt();
        end

        // stall decode until the queue fills
        @(posedge clk);
        flush       <= 1'b0;
        dec_allowin <= 1'b0;
        fetch_valid <= 1'b1;
        fetch_pkt   <= make_pkt();
        k = 0;
        @(negedge clk);
        while (fetch_ready && k < 40) begin
            @(posedge clk);
            fetch_pkt <= make_pkt();
            @(negedge clk);
            k++;
        end
        if (fetch_ready) stop_with_failure("timeout: fetch_ready stayed high while stalled");
        repeat (4) begin
            @(posedge clk);
            fetch_pkt <= make_pkt();  // refused while full
        end

        // release and drain
        @(posedge clk);
        fetch_valid <= 1'b0;
        dec_allowin <= 1'b1;
        @(posedge clk);
        k = 0;
        @(negedge clk);
        while (dec_out.valid && k < 64) begin
            @(negedge clk);
            k++;
        end
        if (dec_out.valid) stop_with_failure("timeout: the queue never drained");
        compare_pair(dec_out, model_pair(1'b0, nop_packet()));
        compare_bit(fetch_ready, 1'b1, "fetch_ready after drain");

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== frontend_top.sv ====
module frontend_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 fetch_valid,
    input  pipe_pkg::fetch_pkt_t fetch_pkt,
    output logic                 fetch_ready,
    input  logic                 dec_allowin,
    output pipe_pkg::dec_pair_t  dec_out
);

    logic                 q_valid;
    pipe_pkg::fetch_pkt_t q_pkt;
    logic                 q_ready;
    logic                 id_valid;
    pipe_pkg::fetch_pkt_t id_pkt;

    inst_queue u_queue (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .push_valid (fetch_valid),
        .push_pkt   (fetch_pkt),
        .push_ready (fetch_ready),
        .pop_valid  (q_valid),
        .pop_pkt    (q_pkt),
        .pop_ready  (q_ready)
    );

    queue_id_reg u_id_reg (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .q_valid     (q_valid),
        .q_pkt       (q_pkt),
        .q_ready     (q_ready),
        .dec_allowin (dec_allowin),
        .id_valid    (id_valid),
        .id_pkt      (id_pkt)
    );

    // combinational, result leaves in the same cycle
    inst_decode u_decode (
        .id_valid (id_valid),
        .id_pkt   (id_pkt),
        .dec_out  (dec_out)
    );

endmodule

// ==== inst_decode.sv ====
module inst_decode (
    input  logic                 id_valid,
    input  pipe_pkg::fetch_pkt_t id_pkt,
    output pipe_pkg::dec_pair_t  dec_out
);

    // decode one instruction word, slot_pc is the address of this word
    function automatic isa_pkg::dec_op_t decode_slot(
        input logic [31:0] inst,
        input logic [31:0] slot_pc
    );
        isa_pkg::inst_word_u w;
        isa_pkg::dec_op_t    op;
        logic [31:0]         sext;

        w    = inst;
        op   = '0;
        sext = {{16{w.i_form.imm[15]}}, w.i_form.imm};

        case (w.r_form.op)
            isa_pkg::op_alu_reg: begin
                op.cls    = isa_pkg::cls_alu;
                op.alu_fn = w.r_form.func[1:0];
                op.rd     = w.r_form.rd;
                op.rj     = w.r_form.rj;
                op.rk     = w.r_form.rk;
            end
            isa_pkg::op_alu_imm: begin
                op.cls     = isa_pkg::cls_alu;
                op.use_imm = 1'b1;
                op.rd      = w.i_form.rd;
                op.rj      = w.i_form.rj;
                op.imm     = sext;
            end
            isa_pkg::op_branch: begin
                // rd and rj carry the compared registers
                op.cls    = isa_pkg::cls_branch;
                op.rd     = w.i_form.rd;
                op.rj     = w.i_form.rj;
                op.imm    = sext;
                op.target = slot_pc + {sext[29:0], 2'b00};  // word offset
            end
            isa_pkg::op_nop: begin
                op.cls = isa_pkg::cls_nop;
            end
            default: begin
                op.cls = isa_pkg::cls_illegal;  // everything else stays zero
            end
        endcase

        return op;
    endfunction

    logic [31:0] pc_slot1;

    assign pc_slot1 = id_pkt.pc + 32'd4;  // second word of the pair

    always_comb begin
        dec_out             = '0;
        dec_out.valid       = id_valid;
        dec_out.pc          = id_pkt.pc;
        dec_out.slot0       = decode_slot(id_pkt.inst0, id_pkt.pc);
        dec_out.slot1       = decode_slot(id_pkt.inst1, pc_slot1);
        dec_out.pred_taken  = id_pkt.pred_taken;
        dec_out.pred_target = id_pkt.pred_target;
        dec_out.excp_code   = id_pkt.excp_code;
        dec_out.excp_valid  = id_pkt.excp_valid;
    end

endmodule

// ==== inst_queue.sv ====
module inst_queue (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 push_valid,
    input  pipe_pkg::fetch_pkt_t push_pkt,
    output logic                 push_ready,
    output logic                 pop_valid,
    output pipe_pkg::fetch_pkt_t pop_pkt,
    input  logic                 pop_ready
);

    pipe_pkg::fetch_pkt_t mem [pipe_pkg::queue_depth];

    logic [pipe_pkg::queue_ptr_w-1:0] wr_ptr;
    logic [pipe_pkg::queue_ptr_w-1:0] rd_ptr;
    logic [pipe_pkg::queue_cnt_w-1:0] count;

    logic do_push;
    logic do_pop;

    // full check ignores a pop in the same cycle
    assign push_ready = (count != pipe_pkg::queue_depth);
    assign pop_valid  = (count != 0);
    assign pop_pkt    = mem[rd_ptr];  // head entry

    assign do_push = push_valid && push_ready && !flush;  // flush drops the push
    assign do_pop  = pop_valid && pop_ready;

    // storage, no reset needed since count guards every read
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == pipe_pkg::queue_depth - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == pipe_pkg::queue_depth - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

    // opcode sits in the top six bits of every instruction word
    localparam logic [5:0] op_alu_reg = 6'h00;
    localparam logic [5:0] op_alu_imm = 6'h08;
    localparam logic [5:0] op_branch  = 6'h10;
    localparam logic [5:0] op_nop     = 6'h15;

    // filler word used when the decode register has nothing valid
    localparam logic [31:0] inst_nop = {op_nop, 26'd0};

    // register-register format
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [10:0] func;   // low two bits select the alu function
    } r_form_t;

    // register-immediate format, also used by branches
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [15:0] imm;    // signed, word offset for branches
    } i_form_t;

    // one instruction word seen through either format
    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } inst_word_u;

    typedef enum logic [1:0] {
        cls_nop     = 2'd0,
        cls_alu     = 2'd1,
        cls_branch  = 2'd2,
        cls_illegal = 2'd3
    } op_class_e;

    // one decoded operation handed to issue
    typedef struct packed {
        op_class_e   cls;
        logic        use_imm;
        logic [1:0]  alu_fn;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;     // already sign extended
        logic [31:0] target;  // branch target, zero for other classes
    } dec_op_t;

endpackage

// ==== pipe_pkg.sv ====
package pipe_pkg;

    // first fetch address after reset
    localparam logic [31:0] pc_reset = 32'h1c00_0000;

    localparam int queue_depth = 8;
    localparam int queue_ptr_w = $clog2(queue_depth);
    localparam int queue_cnt_w = $clog2(queue_depth + 1);  // count reaches queue_depth

    // one fetch packet, two instruction words at pc and pc+4
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [1:0]  pred_taken;   // bit 0 for slot 0, bit 1 for slot 1
        logic [31:0] pred_target;
        logic [6:0]  excp_code;
        logic        excp_valid;
    } fetch_pkt_t;

    // what the decode register holds when it is empty
    localparam fetch_pkt_t nop_pkt = '{
        pc:          pc_reset,
        inst0:       isa_pkg::inst_nop,
        inst1:       isa_pkg::inst_nop,
        pred_taken:  2'b00,
        pred_target: pc_reset + 32'd8,
        excp_code:   7'd0,
        excp_valid:  1'b0
    };

    // decoded pair sent on to issue
    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        isa_pkg::dec_op_t slot0;
        isa_pkg::dec_op_t slot1;
        logic [1:0]       pred_taken;
        logic [31:0]      pred_target;
        logic [6:0]       excp_code;
        logic             excp_valid;
    } dec_pair_t;

endpackage

// ==== queue_id_reg.sv ====
module queue_id_reg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 q_valid,
    input  pipe_pkg::fetch_pkt_t q_pkt,
    output logic                 q_ready,
    input  logic                 dec_allowin,
    output logic                 id_valid,
    output pipe_pkg::fetch_pkt_t id_pkt
);

    logic clear;
    logic load;

    // the register is always ready when decode is
    assign q_ready = dec_allowin;

    // decode asked for more but the queue had nothing
    assign clear = reset || flush || (dec_allowin && !q_valid);
    assign load  = q_valid && q_ready;

    // valid flag
    always_ff @(posedge clk) begin
        if (clear) begin
            id_valid <= 1'b0;
        end else if (load) begin
            id_valid <= 1'b1;
        end
    end

    // payload drops back to a nop bundle so decode always sees legal words
    always_ff @(posedge clk) begin
        if (clear) begin
            id_pkt <= pipe_pkg::nop_pkt;
        end else if (load) begin
            id_pkt <= q_pkt;
        end
    end

endmodule

// ==== sources.f ====
isa_pkg.sv
pipe_pkg.sv
inst_queue.sv
queue_id_reg.sv
inst_decode.sv
frontend_top.sv
frontend_chk.sv
frontend_tb.sv
